//--- design/fpu_defines.svh
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// binary32 layout
`define FP_EXP_W   8
`define FP_FRAC_W  23
`define FP_BIAS    127

// funct7 codes
`define OP_ADD     7'b0000000
`define OP_SUB     7'b0000100
`define OP_MUL     7'b0001000

// frm codes, 5 to 7 are treated as rne
`define RM_RNE     3'd0
`define RM_RTZ     3'd1
`define RM_RDN     3'd2
`define RM_RUP     3'd3
`define RM_RMM     3'd4

`define FP_QNAN    32'h7fc00000
`define FP_EXP_MAX 8'hff

`endif

//--- design/fp_format_pkg.sv
`include "fpu_defines.svh"

package fp_format_pkg;

	typedef struct packed {
		logic                  sign;
		logic [`FP_EXP_W-1:0]  exp;   // biased
		logic [`FP_FRAC_W-1:0] frac;
	} fp_fields_t;

	// one word, compared whole or split into fields
	typedef union packed {
		logic [31:0] raw;
		fp_fields_t  f;
	} fp_word_u;

	typedef struct packed {
		logic is_zero;   // exponent zero, subnormals land here too
		logic is_inf;
		logic is_nan;
		logic is_snan;   // quiet bit clear
		logic is_normal;
	} fp_class_t;

endpackage

//--- design/fpu_op_pkg.sv
`include "fpu_defines.svh"

package fpu_op_pkg;
	import fp_format_pkg::*;

	typedef struct packed {
		logic [6:0] opcode;  // funct7
		logic [2:0] frm;
		fp_word_u   a;
		fp_word_u   b;
	} fp_req_t;

	typedef struct packed {
		fp_req_t   req;
		fp_class_t cls_a;
		fp_class_t cls_b;
	} fp_unpacked_t;

	// unrounded value, sig holds 1.f then guard and sticky
	typedef struct packed {
		logic                  sign;
		logic [`FP_EXP_W+1:0]  exp;  // biased, two's complement
		logic [`FP_FRAC_W+2:0] sig;
		fp_unpacked_t          src;
	} fp_inter_t;

	// fflags order
	typedef struct packed {
		logic nv;
		logic dz;
		logic of;
		logic uf;
		logic nx;
	} fp_flags_t;

	typedef struct packed {
		fp_word_u  word;
		fp_flags_t flags;
	} fp_result_t;

endpackage

//--- design/operand_prep.sv
`include "fpu_defines.svh"

module operand_prep
	import fp_format_pkg::*;
	import fpu_op_pkg::*;
(
	input  logic         clk,
	input  logic         nrst,
	input  logic         in_valid,
	input  fp_req_t      req,
	output logic         up_valid,
	output fp_unpacked_t up
);

	logic supported;

	function automatic fp_class_t classify(fp_word_u w);
		fp_class_t c;
		logic      exp_max;
		exp_max     = (w.f.exp == `FP_EXP_MAX);
		c.is_zero   = (w.f.exp == '0);  // flush subnormals
		c.is_inf    = exp_max && (w.f.frac == '0);
		c.is_nan    = exp_max && (w.f.frac != '0);
		c.is_snan   = c.is_nan && !w.f.frac[`FP_FRAC_W-1];
		c.is_normal = !c.is_zero && !exp_max;
		return c;
	endfunction

	assign supported = (req.opcode == `OP_ADD) || (req.opcode == `OP_SUB) ||
		(req.opcode == `OP_MUL);

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			up_valid <= 1'b0;
		end else begin
			up_valid <= in_valid && supported;  // other opcodes stop here
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			up.req   <= req;
			up.cls_a <= classify(req.a);
			up.cls_b <= classify(req.b);
		end
	end

endmodule

//--- design/fp_add_sub.sv
`include "fpu_defines.svh"

module fp_add_sub
	import fp_format_pkg::*;
	import fpu_op_pkg::*;
(
	input  logic         clk,
	input  logic         nrst,
	input  logic         up_valid,
	input  fp_unpacked_t up,
	output logic         as_valid,
	output fp_inter_t    as
);

	fp_word_u    a, b;
	logic        is_sub, take, swap, eff_sub, sign_l, sign_s;
	logic [7:0]  exp_l, exp_s, diff;
	logic [23:0] sig_a, sig_b, sig_l, sig_s;
	logic [26:0] small_ext, small_sh, lost_mask;
	logic [27:0] addend, sum, norm;
	logic [4:0]  shamt, lz;

	function automatic logic [4:0] lead_zeros(logic [27:0] v);
		logic [4:0] n;
		n = 5'd28;
		for (int i = 0; i < 28; i++) begin
			if (v[i])
				n = 5'(27 - i);
		end
		return n;
	endfunction

	assign a      = up.req.a;
	assign b      = up.req.b;
	assign is_sub = (up.req.opcode == `OP_SUB);
	assign take   = up_valid && (is_sub || (up.req.opcode == `OP_ADD));

	assign sig_a = up.cls_a.is_normal ? {1'b1, a.f.frac} : '0;
	assign sig_b = up.cls_b.is_normal ? {1'b1, b.f.frac} : '0;

	// larger magnitude goes first, b sign flipped for subtract
	assign swap    = b.raw[30:0] > a.raw[30:0];
	assign sign_l  = swap ? (b.f.sign ^ is_sub) : a.f.sign;
	assign sign_s  = swap ? a.f.sign : (b.f.sign ^ is_sub);
	assign exp_l   = swap ? b.f.exp : a.f.exp;
	assign exp_s   = swap ? a.f.exp : b.f.exp;
	assign sig_l   = swap ? sig_b : sig_a;
	assign sig_s   = swap ? sig_a : sig_b;
	assign eff_sub = sign_l ^ sign_s;

	// align with guard, round and sticky
	assign diff      = exp_l - exp_s;
	assign shamt     = (diff > 8'd27) ? 5'd27 : diff[4:0];
	assign small_ext = {sig_s, 3'b000};
	assign small_sh  = small_ext >> shamt;
	assign lost_mask = ~({27{1'b1}} << shamt);
	assign addend    = {1'b0, small_sh[26:1], small_sh[0] | (|(small_ext & lost_mask))};

	assign sum  = eff_sub ? ({1'b0, sig_l, 3'b000} - addend) : ({1'b0, sig_l, 3'b000} + addend);
	assign lz   = lead_zeros(sum);
	assign norm = sum << lz;  // leading one now at bit 27

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			as_valid <= 1'b0;
		end else begin
			as_valid <= take;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			as.src <= up;
			if (sum == '0) begin
				as.sign <= (up.req.frm == `RM_RDN);  // exact cancellation
				as.exp  <= '0;
				as.sig  <= '0;
			end else begin
				as.sign <= sign_l;
				as.exp  <= {2'b00, exp_l} + 10'd1 - {5'd0, lz};
				as.sig  <= {norm[27:3], |norm[2:0]};
			end
		end
	end

endmodule

//--- design/fp_mul.sv
`include "fpu_defines.svh"

module fp_mul
	import fp_format_pkg::*;
	import fpu_op_pkg::*;
(
	input  logic         clk,
	input  logic         nrst,
	input  logic         up_valid,
	input  fp_unpacked_t up,
	output logic         mu_valid,
	output fp_inter_t    mu
);

	fp_word_u    a, b;
	logic        take;
	logic [23:0] sig_a, sig_b;
	logic [47:0] prod, pn;

	assign a     = up.req.a;
	assign b     = up.req.b;
	assign take  = up_valid && (up.req.opcode == `OP_MUL);
	assign sig_a = up.cls_a.is_normal ? {1'b1, a.f.frac} : '0;
	assign sig_b = up.cls_b.is_normal ? {1'b1, b.f.frac} : '0;

	assign prod = sig_a * sig_b;
	assign pn   = prod[47] ? prod : (prod << 1);  // product is in [1,4)

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			mu_valid <= 1'b0;
		end else begin
			mu_valid <= take;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			mu.src  <= up;
			mu.sign <= a.f.sign ^ b.f.sign;
			mu.exp  <= {2'b00, a.f.exp} + {2'b00, b.f.exp} - 10'(`FP_BIAS) + {9'd0, prod[47]};
			mu.sig  <= {pn[47:23], |pn[22:0]};  // low bits fold into sticky
		end
	end

endmodule

//--- design/fp_rounder.sv
`include "fpu_defines.svh"

module fp_rounder
	import fp_format_pkg::*;
	import fpu_op_pkg::*;
(
	input  fp_inter_t inter,
	output fp_word_u  rounded,
	output logic      of,
	output logic      uf,
	output logic      nx
);

	logic              guard, sticky, inexact, round_up, to_inf;
	logic [24:0]       bumped;
	logic signed [9:0] exp_r;

	assign guard   = inter.sig[1];
	assign sticky  = inter.sig[0];
	assign inexact = guard | sticky;

	always_comb begin
		case (inter.src.req.frm)
			`RM_RTZ: begin
				round_up = 1'b0;
				to_inf   = 1'b0;
			end
			`RM_RDN: begin
				round_up = inexact & inter.sign;
				to_inf   = inter.sign;
			end
			`RM_RUP: begin
				round_up = inexact & ~inter.sign;
				to_inf   = ~inter.sign;
			end
			`RM_RMM: begin
				round_up = guard;
				to_inf   = 1'b1;
			end
			`RM_RNE, 3'd5, 3'd6, 3'd7: begin
				round_up = guard & (sticky | inter.sig[2]);  // ties to even
				to_inf   = 1'b1;
			end
		endcase
	end

	// a carry out leaves 1.0, so the exponent steps and frac is zero
	assign bumped = {1'b0, inter.sig[25:2]} + {24'd0, round_up};
	assign exp_r  = inter.exp + {9'd0, bumped[24]};

	always_comb begin
		rounded.raw = {inter.sign, 31'd0};
		of          = 1'b0;
		uf          = 1'b0;
		nx          = 1'b0;
		if (inter.sig != '0) begin
			if (exp_r < 10'sd1) begin
				uf = 1'b1;  // tiny, flush to signed zero
				nx = 1'b1;
			end else if (exp_r >= $signed({2'b00, `FP_EXP_MAX})) begin
				of = 1'b1;
				nx = 1'b1;
				if (to_inf)
					rounded.raw = {inter.sign, `FP_EXP_MAX, 23'd0};
				else
					rounded.raw = {inter.sign, `FP_EXP_MAX - 8'd1, {23{1'b1}}};
			end else begin
				rounded.f.sign = inter.sign;
				rounded.f.exp  = exp_r[7:0];
				rounded.f.frac = bumped[22:0];
				nx             = inexact;
			end
		end
	end

endmodule

//--- design/result_determine.sv
`include "fpu_defines.svh"

module result_determine
	import fp_format_pkg::*;
	import fpu_op_pkg::*;
(
	input  logic       clk,
	input  logic       nrst,
	input  logic       in_valid,
	input  fp_inter_t  inter,
	output logic       out_valid,
	output fp_result_t res
);

	fp_word_u  a, b, rounded, word;
	fp_class_t ca, cb;
	fp_flags_t flags;
	logic      of, uf, nx, nv, special;
	logic      is_mul, sign_b, sign_p, zero_sign;

	fp_rounder fp_rounder_i (
		.inter   (inter),
		.rounded (rounded),
		.of      (of),
		.uf      (uf),
		.nx      (nx)
	);

	assign a      = inter.src.req.a;
	assign b      = inter.src.req.b;
	assign ca     = inter.src.cls_a;
	assign cb     = inter.src.cls_b;
	assign is_mul = (inter.src.req.opcode == `OP_MUL);
	assign sign_b = b.f.sign ^ (inter.src.req.opcode == `OP_SUB);  // effective sign of b
	assign sign_p = a.f.sign ^ b.f.sign;

	// +0 unless both negative; opposite signs give -0 under rdn
	assign zero_sign = (a.f.sign & sign_b) |
		((a.f.sign ^ sign_b) & (inter.src.req.frm == `RM_RDN));

	always_comb begin
		special = 1'b1;
		nv      = 1'b0;
		word    = rounded;
		if (ca.is_nan || cb.is_nan) begin
			word.raw = `FP_QNAN;
			nv       = ca.is_snan || cb.is_snan;
		end else if (is_mul && ((ca.is_inf && cb.is_zero) || (ca.is_zero && cb.is_inf))) begin
			word.raw = `FP_QNAN;
			nv       = 1'b1;
		end else if (is_mul && (ca.is_inf || cb.is_inf)) begin
			word.raw = {sign_p, `FP_EXP_MAX, 23'd0};
		end else if (is_mul && (ca.is_zero || cb.is_zero)) begin
			word.raw = {sign_p, 31'd0};
		end else if (is_mul) begin
			special = 1'b0;
		end else if (ca.is_inf && cb.is_inf && (a.f.sign != sign_b)) begin
			word.raw = `FP_QNAN;  // inf - inf
			nv       = 1'b1;
		end else if (ca.is_inf) begin
			word.raw = {a.f.sign, `FP_EXP_MAX, 23'd0};
		end else if (cb.is_inf) begin
			word.raw = {sign_b, `FP_EXP_MAX, 23'd0};
		end else if (ca.is_zero && cb.is_zero) begin
			word.raw = {zero_sign, 31'd0};
		end else if (ca.is_zero) begin
			word.raw = {sign_b, b.raw[30:0]};
		end else if (cb.is_zero) begin
			word = a;
		end else begin
			special = 1'b0;
		end
	end

	assign flags = '{nv: nv, dz: 1'b0, of: of & ~special, uf: uf & ~special, nx: nx & ~special};

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			out_valid <= 1'b0;
			res       <= '0;
		end else begin
			out_valid <= in_valid;
			if (in_valid) begin
				res.word  <= word;
				res.flags <= flags;
			end
		end
	end

endmodule

//--- design/fpu_top.sv
module fpu_top
	import fpu_op_pkg::*;
(
	input  logic       clk,
	input  logic       nrst,
	input  logic       in_valid,
	input  fp_req_t    req,
	output logic       out_valid,
	output fp_result_t res
);

	logic         up_valid, as_valid, mu_valid, st2_valid;
	fp_unpacked_t up;
	fp_inter_t    as, mu, st2;

	operand_prep operand_prep_i (
		.clk      (clk),
		.nrst     (nrst),
		.in_valid (in_valid),
		.req      (req),
		.up_valid (up_valid),
		.up       (up)
	);

	fp_add_sub fp_add_sub_i (
		.clk      (clk),
		.nrst     (nrst),
		.up_valid (up_valid),
		.up       (up),
		.as_valid (as_valid),
		.as       (as)
	);

	fp_mul fp_mul_i (
		.clk      (clk),
		.nrst     (nrst),
		.up_valid (up_valid),
		.up       (up),
		.mu_valid (mu_valid),
		.mu       (mu)
	);

	// only one path fires per request
	assign st2_valid = as_valid | mu_valid;
	assign st2       = mu_valid ? mu : as;

	result_determine result_determine_i (
		.clk       (clk),
		.nrst      (nrst),
		.in_valid  (st2_valid),
		.inter     (st2),
		.out_valid (out_valid),
		.res       (res)
	);

endmodule

//--- verif/fpu_tb.sv
`include "fpu_defines.svh"

module fpu_tb
	import fpu_op_pkg::*;
();

	logic       clk;
	logic       nrst;
	logic       in_valid;
	fp_req_t    req;
	logic       out_valid;
	fp_result_t res;

	logic [6:0]  vec_op    [0:63];
	logic [2:0]  vec_frm   [0:63];
	logic [31:0] vec_a     [0:63];
	logic [31:0] vec_b     [0:63];
	logic [31:0] vec_res   [0:63];
	logic [4:0]  vec_flags [0:63];
	int          n_vec;

	// expectations in issue order
	logic [31:0] want_res_q   [$];
	logic [4:0]  want_flags_q [$];
	int          want_edge_q  [$];

	logic [16:0] lfsr;
	int          edges;  // rising edges seen so far
	int          errors;
	int          checks;
	bit          requested;

	fpu_top fpu_top_i (
		.clk       (clk),
		.nrst      (nrst),
		.in_valid  (in_valid),
		.req       (req),
		.out_valid (out_valid),
		.res       (res)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	always @(posedge clk) edges <= edges + 1;

	// x^17 + x^14 + 1
	function automatic logic [16:0] lfsr_next(logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	function automatic bit supported(logic [6:0] op);
		return (op == `OP_ADD) || (op == `OP_SUB) || (op == `OP_MUL);
	endfunction

	task automatic draw_gap(output int gap);
		gap = 0;
		for (int k = 0; k < 2; k++) begin
			lfsr = lfsr_next(lfsr);
			gap  = (gap << 1) | lfsr[0];  // one step per bit
		end
	endtask

	task automatic load_trace(output bit loaded);
		int               fd;
		int               n;
		logic [31:0]      f_op, f_frm, f_a, f_b, f_res, f_flags;
		logic [8*128-1:0] line;
		loaded = 1'b0;
		n_vec  = 0;
		fd     = $fopen("verif/fpu_trace.txt", "r");
		if (fd != 0) begin
			loaded = 1'b1;
			while (!$feof(fd) && n_vec < 64) begin
				line = '0;
				n    = $fgets(line, fd);
				n    = $sscanf(line, "%h %h %h %h %h %h", f_op, f_frm, f_a, f_b, f_res, f_flags);
				if (n == 6) begin  // comment and blank lines fall through
					vec_op[n_vec]    = f_op[6:0];
					vec_frm[n_vec]   = f_frm[2:0];
					vec_a[n_vec]     = f_a;
					vec_b[n_vec]     = f_b;
					vec_res[n_vec]   = f_res;
					vec_flags[n_vec] = f_flags[4:0];
					n_vec++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic issue_vec(int i);
		@(posedge clk);
		in_valid  <= 1'b1;
		req       <= {vec_op[i], vec_frm[i], vec_a[i], vec_b[i]};
		requested = 1'b1;
		if (supported(vec_op[i])) begin
			want_res_q.push_back(vec_res[i]);
			want_flags_q.push_back(vec_flags[i]);
			want_edge_q.push_back(edges + 4);  // current edge plus three
		end
	endtask

	task automatic run_pass(input bit gapped, output bit drained);
		int gap;
		int wait_cycles;
		for (int i = 0; i < n_vec; i++) begin
			gap = 0;
			if (gapped)
				draw_gap(gap);
			issue_vec(i);
			for (int g = 0; g < gap; g++) begin
				@(posedge clk);
				in_valid <= 1'b0;
			end
		end
		@(posedge clk);
		in_valid    <= 1'b0;
		wait_cycles = 0;
		while (want_res_q.size() != 0 && wait_cycles < 20) begin
			@(posedge clk);
			wait_cycles++;
		end
		drained = (want_res_q.size() == 0);
		repeat (4) @(posedge clk);  // room for a stray out_valid
	endtask

	// outputs sampled mid-cycle
	always @(negedge clk) begin
		if (!requested) begin
			checks = checks + 1;
			if (out_valid !== 1'b0) begin
				$display("Fail t=%0t out_valid expected 0 got %b", $time, out_valid);
				errors = errors + 1;
			end
			if (res !== '0) begin
				$display("Fail t=%0t res expected %h got %h", $time, 37'd0, res);
				errors = errors + 1;
			end
		end else if (out_valid === 1'b1) begin
			if (want_res_q.size() == 0) begin
				$display("Error at %0t: out_valid rose with no request outstanding", $time);
				errors = errors + 1;
			end else begin
				checks = checks + 1;
				if (res.word.raw !== want_res_q[0]) begin
					$display("Fail t=%0t res.word expected %h got %h", $time,
						want_res_q[0], res.word.raw);
					errors = errors + 1;
				end
				if (res.flags !== want_flags_q[0]) begin
					$display("Fail t=%0t res.flags expected %b got %b", $time,
						want_flags_q[0], res.flags);
					errors = errors + 1;
				end
				if (edges != want_edge_q[0]) begin
					$display("Fail t=%0t out_valid edge expected %0d got %0d", $time,
						want_edge_q[0], edges);
					errors = errors + 1;
				end
				void'(want_res_q.pop_front());
				void'(want_flags_q.pop_front());
				void'(want_edge_q.pop_front());
			end
		end
	end

	initial begin
		bit loaded;
		bit ok;
		int base;
		nrst      = 1'b0;
		in_valid  = 1'b0;
		req       = '0;
		lfsr      = 17'd98517;
		edges     = 0;
		errors    = 0;
		checks    = 0;
		requested = 1'b0;
		ok        = 1'b1;
		load_trace(loaded);
		if (!loaded || n_vec == 0) begin
			$display("Error: trace file verif/fpu_trace.txt could not be read");
			ok = 1'b0;
		end else begin
			repeat (10) @(posedge clk);
			nrst <= 1'b1;
			repeat (3) @(posedge clk);  // idle after reset, outputs still quiet
			$display("test reset: %0d errors", errors);
			base = errors;
			run_pass(1'b1, ok);
			$display("test gapped trace: %0d vectors, %0d errors", n_vec, errors - base);
			if (ok) begin
				base = errors;
				run_pass(1'b0, ok);
				$display("test back-to-back: %0d vectors, %0d errors", n_vec, errors - base);
			end
			if (!ok)
				$display("Error at %0t: results still outstanding, pipeline timed out", $time);
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (ok && errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- verif/fpu_trace.txt
// funct7 frm operand_a operand_b expected_result expected_flags
// flags are nv dz of uf nx, every field in hex
00 0 3f800000 40000000 40400000 00
04 0 3f800000 3f800000 00000000 00
04 2 3f800000 3f800000 80000000 00
00 0 3f800000 33800000 3f800000 01
00 1 3f800000 33800000 3f800000 01
00 2 3f800000 33800000 3f800000 01
00 3 3f800000 33800000 3f800001 01
00 4 3f800000 33800000 3f800001 01
04 2 bf800000 33800000 bf800001 01
04 3 bf800000 33800000 bf800000 01
04 0 3fc00000 3fa00000 3e800000 00
08 0 3fc00000 3fc00000 40100000 00
08 0 40000000 40400000 40c00000 00
08 0 3f800001 3ffffffe 40000000 01
08 1 3f800001 3ffffffe 3fffffff 01
00 0 7fc00000 3f800000 7fc00000 00
08 0 7f800001 3f800000 7fc00000 10
04 0 7f800000 7f800000 7fc00000 10
08 0 7f800000 00000000 7fc00000 10
08 0 ff800000 40000000 ff800000 00
04 0 00000000 40400000 c0400000 00
08 0 80000000 40a00000 80000000 00
00 0 00400000 3f800000 3f800000 00
0c 0 3f800000 40000000 00000000 00
08 0 7f7fffff 40000000 7f800000 05
08 1 7f7fffff 40000000 7f7fffff 05
08 3 ff7fffff 40000000 ff7fffff 05
08 0 0d800000 0d800000 00000000 03
08 0 8d800000 0d800000 80000000 03

//--- all.f
+incdir+design
design/fp_format_pkg.sv
design/fpu_op_pkg.sv
design/operand_prep.sv
design/fp_add_sub.sv
design/fp_mul.sv
design/fp_rounder.sv
design/result_determine.sv
design/fpu_top.sv
verif/fpu_tb.sv
